//--- apu_consts.svh
`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

//////////////////////////////
// register window

`define APU_BASE 16'h4000
`define APU_SIZE 32

`define REG_STATUS 5'h15
`define REG_FRAME 5'h17

//////////////////////////////
// frame sequencer step reloads, in channel ticks

`define FRAME_LOAD_0 12'd3727
`define FRAME_LOAD_1 12'd3727
`define FRAME_LOAD_2 12'd3728
`define FRAME_LOAD_3 12'd3728
`define FRAME_LOAD_4 12'd3725

//////////////////////////////
// mixer weights

`define MIX_PULSE_W 8'd4
`define MIX_TRI_W 8'd3

`endif

//--- apu_pkg.sv
`default_nettype none

package apu_pkg;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic we;
		logic re;
	} bus_req_t;

	typedef struct packed {
		logic [1:0] reg_idx;
		logic [7:0] data;
		logic stb; // one sys_clk cycle wide
	} chan_wr_t;

	typedef struct packed {
		logic [1:0] duty;
		logic halt;
		logic const_vol;
		logic [3:0] vol;
	} pulse_ctrl_t;

	typedef struct packed {
		logic halt; // also the linear counter control flag
		logic [6:0] linear_load;
	} tri_ctrl_t;

	// register 0 of a channel reads differently for pulse and triangle
	typedef union packed {
		pulse_ctrl_t pulse;
		tri_ctrl_t triangle;
	} ctrl_word_u;

	typedef struct packed {
		logic quarter;
		logic half;
	} frame_strobe_t;

endpackage

`default_nettype wire

//--- apu_length.sv
`timescale 1ns/10ps
`default_nettype none

module apu_length (
	input wire sys_clk,
	input wire sys_n_reset,
	input wire load_stb,
	input wire [4:0] load_idx,
	input wire halt,
	input wire en,
	input wire half,
	output logic act
);

	localparam logic [7:0] LEN_TABLE [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	logic [7:0] cnt;

	always_ff @(posedge sys_clk, negedge sys_n_reset) begin
		if (!sys_n_reset)
			cnt <= 8'd0;
		else if (!en)
			cnt <= 8'd0; // a disabled channel drops out at once
		else if (load_stb)
			cnt <= LEN_TABLE[load_idx];
		else if (half && !halt && cnt != 8'd0)
			cnt <= cnt - 8'd1;
	end

	assign act = cnt != 8'd0;

endmodule

`default_nettype wire

//--- apu_reg_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "apu_consts.svh"

module apu_reg_decode import apu_pkg::*; (
	input wire sys_clk,
	input wire sys_n_reset,
	input wire bus_req_t bus,
	input wire [2:0] act,
	input wire frame_irq,
	output logic [7:0] rdata,
	output chan_wr_t pulse0_wr,
	output chan_wr_t pulse1_wr,
	output chan_wr_t tri_wr,
	output logic [2:0] chan_en,
	output logic frame_wr,
	output logic frame_mode,
	output logic frame_inhibit,
	output logic stat_read
);

	localparam logic [15:0] WIN_MASK = 16'(~(`APU_SIZE - 1));

	logic hit;
	logic wr_hit;
	logic [4:0] offset;

	assign hit = (bus.addr & WIN_MASK) == `APU_BASE;
	assign offset = bus.addr[4:0];
	assign wr_hit = hit && bus.we;

	always_ff @(posedge sys_clk, negedge sys_n_reset) begin
		if (!sys_n_reset) begin
			pulse0_wr <= '0;
			pulse1_wr <= '0;
			tri_wr <= '0;
			chan_en <= 3'b000;
			frame_wr <= 1'b0;
			frame_mode <= 1'b0;
			frame_inhibit <= 1'b0;
		end else begin
			pulse0_wr <= '{reg_idx: offset[1:0], data: bus.wdata, stb: wr_hit && offset[4:2] == 3'd0};
			pulse1_wr <= '{reg_idx: offset[1:0], data: bus.wdata, stb: wr_hit && offset[4:2] == 3'd1};
			tri_wr <= '{reg_idx: offset[1:0], data: bus.wdata, stb: wr_hit && offset[4:2] == 3'd2};
			frame_wr <= wr_hit && offset == `REG_FRAME; // restart reaches the sequencer next cycle
			if (wr_hit && offset == `REG_STATUS)
				chan_en <= bus.wdata[2:0]; // noise and sample enables are not kept
			if (wr_hit && offset == `REG_FRAME) begin
				frame_mode <= bus.wdata[7];
				frame_inhibit <= bus.wdata[6];
			end
		end
	end

	assign stat_read = hit && bus.re && offset == `REG_STATUS;
	assign rdata = stat_read ? {1'b0, frame_irq, 3'b000, act} : 8'h00;

	a_one_chan_wr: assert property (@(posedge sys_clk) disable iff (!sys_n_reset)
		$onehot0({pulse0_wr.stb, pulse1_wr.stb, tri_wr.stb}))
		else $error("more than one channel write strobe");

endmodule

`default_nettype wire

//--- apu_frame_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "apu_consts.svh"

module apu_frame_seq import apu_pkg::*; (
	input wire sys_clk,
	input wire sys_n_reset,
	input wire frame_wr,
	input wire frame_mode,
	input wire frame_inhibit,
	input wire stat_read,
	output logic apu_tick,
	output frame_strobe_t strobes,
	output logic frame_irq
);

	typedef enum logic [2:0] {ST1, ST2, ST3, ST4, ST5} step_e;

	step_e state;
	logic [11:0] cnt;
	logic step_end;
	logic int_set;
	logic int_clr;

	always_ff @(posedge sys_clk, negedge sys_n_reset) begin
		if (!sys_n_reset)
			apu_tick <= 1'b0;
		else
			apu_tick <= ~apu_tick; // channel rate is half of sys_clk
	end

	//////////////////////////////
	// step machine

	always_ff @(posedge sys_clk, negedge sys_n_reset) begin
		if (!sys_n_reset) begin
			state <= ST1;
			cnt <= `FRAME_LOAD_0;
			strobes <= '0;
		end else begin
			strobes <= '0;
			if (frame_wr) begin
				state <= ST1;
				cnt <= `FRAME_LOAD_0;
			end else if (apu_tick) begin
				if (cnt == 12'd0) begin
					case (state)
					ST1: begin
						state <= ST2;
						cnt <= `FRAME_LOAD_1;
						strobes <= '{quarter: 1'b1, half: 1'b0};
					end
					ST2: begin
						state <= ST3;
						cnt <= `FRAME_LOAD_2;
						strobes <= '{quarter: 1'b1, half: 1'b1};
					end
					ST3: begin
						state <= ST4;
						cnt <= `FRAME_LOAD_3;
						strobes <= '{quarter: 1'b1, half: 1'b0};
					end
					ST4: begin
						if (frame_mode) begin
							state <= ST5; // step 4 is silent in 5-step mode
							cnt <= `FRAME_LOAD_4;
						end else begin
							state <= ST1;
							cnt <= `FRAME_LOAD_0;
							strobes <= '{quarter: 1'b1, half: 1'b1};
						end
					end
					default: begin
						state <= ST1;
						cnt <= `FRAME_LOAD_0;
						strobes <= '{quarter: 1'b1, half: 1'b1};
					end
					endcase
				end else begin
					cnt <= cnt - 12'd1;
				end
			end
		end
	end

	//////////////////////////////
	// frame interrupt

	assign step_end = apu_tick && cnt == 12'd0 && !frame_wr;
	assign int_set = step_end && state == ST4 && !frame_mode && !frame_inhibit;
	assign int_clr = frame_inhibit || stat_read;

	always_ff @(posedge sys_clk, negedge sys_n_reset) begin
		if (!sys_n_reset)
			frame_irq <= 1'b0;
		else if (int_set)
			frame_irq <= 1'b1; // a status read on the same edge loses
		else if (int_clr)
			frame_irq <= 1'b0;
	end

	a_half_has_quarter: assert property (@(posedge sys_clk) disable iff (!sys_n_reset)
		strobes.half |-> strobes.quarter)
		else $error("half frame strobe without quarter");

endmodule

`default_nettype wire

//--- apu_pulse.sv
`timescale 1ns/10ps
`default_nettype none

module apu_pulse import apu_pkg::*; (
	input wire sys_clk,
	input wire sys_n_reset,
	input wire chan_wr_t wr,
	input wire en,
	input wire apu_tick,
	input wire frame_strobe_t strobes,
	output logic [3:0] sample,
	output logic act
);

	ctrl_word_u ctrl;
	logic [10:0] period;
	logic [10:0] timer;
	logic [2:0] step;
	logic len_load;

	function automatic logic duty_bit(input logic [1:0] duty, input logic [2:0] s);
		logic [7:0] pattern;
		case (duty)
		2'd0: pattern = 8'b0100_0000;
		2'd1: pattern = 8'b0110_0000;
		2'd2: pattern = 8'b0111_1000;
		default: pattern = 8'b1001_1111;
		endcase
		return pattern[3'd7 - s];
	endfunction

	assign len_load = wr.stb && wr.reg_idx == 2'd3;

	always_ff @(posedge sys_clk, negedge sys_n_reset) begin
		if (!sys_n_reset) begin
			ctrl <= '0;
			period <= 11'd0;
			timer <= 11'd0;
			step <= 3'd0;
		end else begin
			if (wr.stb) begin
				case (wr.reg_idx)
				2'd0: ctrl <= wr.data;
				2'd2: period[7:0] <= wr.data;
				2'd3: period[10:8] <= wr.data[2:0];
				default: ; // sweep register has no effect
				endcase
			end
			if (len_load) begin
				timer <= {wr.data[2:0], period[7:0]};
				step <= 3'd0;
			end else if (apu_tick) begin
				if (timer == 11'd0) begin
					timer <= period;
					step <= step + 3'd1;
				end else begin
					timer <= timer - 11'd1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk, negedge sys_n_reset) begin
		if (!sys_n_reset)
			sample <= 4'd0;
		else if (duty_bit(ctrl.pulse.duty, step) && act && period >= 11'd8)
			sample <= ctrl.pulse.vol;
		else
			sample <= 4'd0; // periods below 8 are muted
	end

	apu_length len (
		.sys_clk(sys_clk),
		.sys_n_reset(sys_n_reset),
		.load_stb(len_load),
		.load_idx(wr.data[7:3]),
		.halt(ctrl.pulse.halt),
		.en(en),
		.half(strobes.half),
		.act(act)
	);

endmodule

`default_nettype wire

//--- apu_triangle.sv
`timescale 1ns/10ps
`default_nettype none

module apu_triangle import apu_pkg::*; (
	input wire sys_clk,
	input wire sys_n_reset,
	input wire chan_wr_t wr,
	input wire en,
	input wire apu_tick,
	input wire frame_strobe_t strobes,
	output logic [3:0] sample,
	output logic act
);

	ctrl_word_u ctrl;
	logic [10:0] period;
	logic [10:0] timer;
	logic [4:0] step;
	logic [4:0] step_nx;
	logic [6:0] lin;
	logic lin_reload;
	logic len_load;

	assign len_load = wr.stb && wr.reg_idx == 2'd3;
	assign step_nx = step + 5'd1;

	always_ff @(posedge sys_clk, negedge sys_n_reset) begin
		if (!sys_n_reset) begin
			ctrl <= '0;
			period <= 11'd0;
			timer <= 11'd0;
			step <= 5'd0;
			lin <= 7'd0;
			lin_reload <= 1'b0;
			sample <= 4'd0;
		end else begin
			if (wr.stb && wr.reg_idx == 2'd0)
				ctrl <= wr.data;
			if (wr.stb && wr.reg_idx == 2'd2)
				period[7:0] <= wr.data;
			if (strobes.quarter) begin
				if (lin_reload)
					lin <= ctrl.triangle.linear_load;
				else if (lin != 7'd0)
					lin <= lin - 7'd1;
				if (!ctrl.triangle.halt)
					lin_reload <= 1'b0;
			end
			if (len_load) begin
				period[10:8] <= wr.data[2:0];
				lin_reload <= 1'b1; // taken on the next quarter strobe
			end
			if (timer == 11'd0) begin
				timer <= period;
				if (lin != 7'd0 && act) begin
					step <= step_nx;
					sample <= step_nx[4] ? step_nx[3:0] : ~step_nx[3:0]; // 15 down to 0, then back up
				end
			end else begin
				timer <= timer - 11'd1;
			end
		end
	end

	apu_length len (
		.sys_clk(sys_clk),
		.sys_n_reset(sys_n_reset),
		.load_stb(len_load),
		.load_idx(wr.data[7:3]),
		.halt(ctrl.triangle.halt),
		.en(en),
		.half(strobes.half),
		.act(act)
	);

endmodule

`default_nettype wire

//--- apu_mixer.sv
`timescale 1ns/10ps
`default_nettype none

`include "apu_consts.svh"

module apu_mixer (
	input wire sys_clk,
	input wire sys_n_reset,
	input wire [3:0] p0,
	input wire [3:0] p1,
	input wire [3:0] tr,
	output logic [7:0] out
);

	logic [7:0] pulse_sum;
	logic [7:0] mix;

	assign pulse_sum = {4'b0000, p0} + {4'b0000, p1};
	assign mix = `MIX_PULSE_W * pulse_sum + `MIX_TRI_W * {4'b0000, tr}; // peaks at 165

	always_ff @(posedge sys_clk, negedge sys_n_reset) begin
		if (!sys_n_reset)
			out <= 8'd0;
		else
			out <= mix;
	end

endmodule

`default_nettype wire

//--- apu_top.sv
`timescale 1ns/10ps
`default_nettype none

module apu_top import apu_pkg::*; (
	input wire sys_clk,
	input wire sys_n_reset,
	input wire bus_req_t bus,
	output logic [7:0] rdata,
	output logic [7:0] out,
	output logic irq
);

	chan_wr_t p0_wr;
	chan_wr_t p1_wr;
	chan_wr_t t_wr;
	frame_strobe_t strobes;
	logic [2:0] chan_en;
	logic [2:0] act;
	logic [3:0] p0_smp;
	logic [3:0] p1_smp;
	logic [3:0] t_smp;
	logic frame_wr;
	logic frame_mode;
	logic frame_inhibit;
	logic stat_read;
	logic frame_irq;
	logic apu_tick;

	//////////////////////////////
	// register decode and frame sequencer

	apu_reg_decode dec (
		.sys_clk(sys_clk), .sys_n_reset(sys_n_reset), .bus(bus), .act(act),
		.frame_irq(frame_irq), .rdata(rdata), .pulse0_wr(p0_wr), .pulse1_wr(p1_wr),
		.tri_wr(t_wr), .chan_en(chan_en), .frame_wr(frame_wr), .frame_mode(frame_mode),
		.frame_inhibit(frame_inhibit), .stat_read(stat_read)
	);

	apu_frame_seq seq (
		.sys_clk(sys_clk), .sys_n_reset(sys_n_reset), .frame_wr(frame_wr),
		.frame_mode(frame_mode), .frame_inhibit(frame_inhibit), .stat_read(stat_read),
		.apu_tick(apu_tick), .strobes(strobes), .frame_irq(frame_irq)
	);

	assign irq = ~frame_irq; // active low at the pin

	//////////////////////////////
	// channels and mixer

	apu_pulse pulse0 (
		.sys_clk(sys_clk), .sys_n_reset(sys_n_reset), .wr(p0_wr), .en(chan_en[0]),
		.apu_tick(apu_tick), .strobes(strobes), .sample(p0_smp), .act(act[0])
	);

	apu_pulse pulse1 (
		.sys_clk(sys_clk), .sys_n_reset(sys_n_reset), .wr(p1_wr), .en(chan_en[1]),
		.apu_tick(apu_tick), .strobes(strobes), .sample(p1_smp), .act(act[1])
	);

	apu_triangle triangle (
		.sys_clk(sys_clk), .sys_n_reset(sys_n_reset), .wr(t_wr), .en(chan_en[2]),
		.apu_tick(apu_tick), .strobes(strobes), .sample(t_smp), .act(act[2])
	);

	apu_mixer mixer (
		.sys_clk(sys_clk), .sys_n_reset(sys_n_reset),
		.p0(p0_smp), .p1(p1_smp), .tr(t_smp), .out(out)
	);

endmodule

`default_nettype wire

//--- apu_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "apu_consts.svh"

module apu_checker import apu_pkg::*; (
	input wire sys_clk,
	input wire bus_req_t bus,
	input wire [7:0] rdata,
	input wire [7:0] out,
	input wire irq,
	input wire [3:0] test_id,
	input wire [1:0] out_mode,
	input wire [3:0] v0,
	input wire [3:0] v1,
	input wire [7:0] stat_exp,
	input wire [7:0] stat_mask,
	input wire irq_high,
	input wire lost,
	output int errors,
	output logic summary_done
);

	localparam logic [3:0] DONE_ID = 4'd15;
	localparam logic [15:0] STAT_ADDR = `APU_BASE + {11'd0, `REG_STATUS};

	logic [3:0] cur_test = 4'd0;
	logic [3:0] held_v0 = 4'd0;
	bit seen [256];
	int test_errs = 0;
	int err_total = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic done_flag = 1'b0;

	assign errors = err_total;
	assign summary_done = done_flag;

	// expected mixer output for two pulse volumes and a triangle level
	function automatic logic [7:0] ref_out(input logic [3:0] a, input logic [3:0] b,
		input logic [3:0] t);
		int sum;
		sum = int'(`MIX_PULSE_W) * (int'(a) + int'(b)) + int'(`MIX_TRI_W) * int'(t);
		return 8'(sum);
	endfunction

	function automatic string test_name(input logic [3:0] id);
		case (id)
		4'd1: return "reset state";
		4'd2: return "pulse0 alone";
		4'd3: return "both pulses";
		4'd4: return "channels disabled";
		4'd5: return "frame interrupt";
		4'd6: return "triangle ramp";
		default: return "unknown";
		endcase
	endfunction

	task automatic count_error();
		test_errs++;
		err_total++;
	endtask

	task automatic report_value(input string name, input logic [7:0] exp,
		input logic [7:0] got);
		$display("FAILED at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, got);
		count_error();
	endtask

	//////////////////////////////
	// per-cycle comparison

	task automatic check_cycle();
		logic hit;
		int t;
		hit = 1'b0;
		held_v0 = v0;
		seen[out] = 1'b1;
		if (lost)
			count_error(); // a wait in the driver timed out
		if (bus.re && bus.addr == STAT_ADDR && stat_mask != 8'h00) begin
			if ((rdata & stat_mask) !== stat_exp)
				report_value("rdata", stat_exp, rdata & stat_mask);
		end
		if (irq_high && irq !== 1'b1)
			report_value("irq", 8'd1, {7'd0, irq});
		case (out_mode)
		2'd1: begin
			if (out !== ref_out(4'd0, 4'd0, 4'd0) && out !== ref_out(v0, 4'd0, 4'd0)
				&& out !== ref_out(4'd0, v1, 4'd0) && out !== ref_out(v0, v1, 4'd0)) begin
				$display("FAILED at %0t: out expected one of %0d %0d %0d %0d, got %0d",
					$time, ref_out(4'd0, 4'd0, 4'd0), ref_out(v0, 4'd0, 4'd0),
					ref_out(4'd0, v1, 4'd0), ref_out(v0, v1, 4'd0), out);
				count_error();
			end
		end
		2'd2: begin
			for (t = 0; t < 16; t++) begin
				if (out === ref_out(4'd0, 4'd0, 4'(t)))
					hit = 1'b1;
			end
			if (!hit) begin
				$display("FAILED at %0t: out expected %0d x (0..15), got %0d",
					$time, ref_out(4'd0, 4'd0, 4'd1), out);
				count_error();
			end
		end
		default: ;
		endcase
	endtask

	//////////////////////////////
	// end of test and summary

	task automatic close_test();
		int distinct;
		int i;
		distinct = 0;
		for (i = 0; i < 256; i++) begin
			if (seen[i])
				distinct++;
		end
		if (cur_test == 4'd2 && (!seen[0] || !seen[ref_out(held_v0, 4'd0, 4'd0)])) begin
			$display("out did not show both 0 and %0d in the pulse window",
				ref_out(held_v0, 4'd0, 4'd0));
			count_error();
		end
		if (cur_test == 4'd6 && distinct < 16) begin
			$display("out showed only %0d distinct triangle levels, 16 were needed", distinct);
			count_error();
		end
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("test %0d (%s): %s, %0d errors", cur_test, test_name(cur_test),
			test_errs == 0 ? "ok" : "failed", test_errs);
	endtask

	always @(negedge sys_clk) begin
		if (test_id != cur_test) begin
			if (cur_test != 4'd0)
				close_test();
			cur_test = test_id;
			test_errs = 0;
			seen = '{default: 1'b0};
			if (cur_test == DONE_ID) begin
				$display("summary: %0d tests run, %0d failed, %0d errors",
					tests_run, tests_failed, err_total);
				done_flag = 1'b1;
			end
		end
		if (cur_test != 4'd0 && cur_test != DONE_ID)
			check_cycle(); // outputs are settled half a cycle after the edge
	end

endmodule

`default_nettype wire

//--- tb_apu.sv
`timescale 1ns/10ps
`default_nettype none

`include "apu_consts.svh"

module tb_apu import apu_pkg::*; ();

	localparam int HALF_PERIOD = 50;

	logic sys_clk;
	logic sys_n_reset;
	bus_req_t bus;
	logic [7:0] rdata;
	logic [7:0] out;
	logic irq;
	logic [3:0] test_id;
	logic [1:0] out_mode;
	logic [3:0] v0;
	logic [3:0] v1;
	logic [7:0] stat_exp;
	logic [7:0] stat_mask;
	logic irq_high;
	logic lost;
	logic [4:0] len_idx;
	int errors;
	logic summary_done;
	int unsigned seed_ret;

	apu_top uut (
		.sys_clk(sys_clk), .sys_n_reset(sys_n_reset), .bus(bus),
		.rdata(rdata), .out(out), .irq(irq)
	);

	apu_checker chk (
		.sys_clk(sys_clk), .bus(bus), .rdata(rdata), .out(out), .irq(irq),
		.test_id(test_id), .out_mode(out_mode), .v0(v0), .v1(v1),
		.stat_exp(stat_exp), .stat_mask(stat_mask), .irq_high(irq_high), .lost(lost),
		.errors(errors), .summary_done(summary_done)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#HALF_PERIOD;
			sys_clk = ~sys_clk;
		end
	end

	//////////////////////////////
	// bus and wait helpers

	task automatic step(input int n);
		repeat (n) @(posedge sys_clk);
		#5; // inputs change just after the edge
	endtask

	function automatic logic [3:0] pick_volume();
		return 4'($urandom % 15) + 4'd1; // never silent
	endfunction

	task automatic write_reg(input logic [4:0] off, input logic [7:0] data);
		bus.addr = `APU_BASE + {11'd0, off};
		bus.wdata = data;
		bus.we = 1'b1;
		step(1);
		bus.we = 1'b0;
	endtask

	task automatic read_status(input logic [7:0] exp, input logic [7:0] mask);
		bus.addr = `APU_BASE + {11'd0, `REG_STATUS};
		bus.re = 1'b1;
		stat_exp = exp;
		stat_mask = mask;
		step(1);
		bus.re = 1'b0;
		stat_mask = 8'h00;
	endtask

	task automatic flag_lost(input string what);
		$display("timeout at %0t: %s", $time, what);
		lost = 1'b1;
		step(1);
		lost = 1'b0;
	endtask

	task automatic wait_irq(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (irq !== level && n < limit) begin
			step(1);
			n++;
		end
		if (irq !== level)
			flag_lost(what);
	endtask

	task automatic wait_out_active(input int limit);
		int n;
		n = 0;
		while (out === 8'd0 && n < limit) begin
			step(1);
			n++;
		end
		if (out === 8'd0)
			flag_lost("triangle output stayed silent");
	endtask

	task automatic wait_summary(input int limit);
		int n;
		n = 0;
		while (summary_done !== 1'b1 && n < limit) begin
			step(1);
			n++;
		end
		if (summary_done !== 1'b1)
			$display("checker did not print its summary");
	endtask

	//////////////////////////////
	// test sequence

	initial begin
		seed_ret = $urandom(32'h36de0826);
		bus = '0;
		test_id = 4'd0;
		out_mode = 2'd0;
		v0 = 4'd0;
		v1 = 4'd0;
		stat_exp = 8'h00;
		stat_mask = 8'h00;
		irq_high = 1'b0;
		lost = 1'b0;
		len_idx = 5'd0;
		sys_n_reset = 1'b0;
		step(10);
		sys_n_reset = 1'b1;

		test_id = 4'd1;
		out_mode = 2'd1;
		irq_high = 1'b1;
		step(4);
		read_status(8'h00, 8'hFF);
		step(4);
		irq_high = 1'b0;

		test_id = 4'd2;
		v0 = pick_volume();
		len_idx = 5'($urandom % 32);
		write_reg(`REG_STATUS, 8'h01);
		write_reg(5'h00, {4'b1011, v0}); // 50% duty, halted length, constant volume
		write_reg(5'h02, 8'd200);
		write_reg(5'h03, {len_idx, 3'b000});
		step(2000);
		read_status(8'h01, 8'h07);

		test_id = 4'd3;
		v1 = pick_volume();
		len_idx = 5'($urandom % 32);
		write_reg(`REG_STATUS, 8'h03);
		write_reg(5'h04, {4'b1011, v1});
		write_reg(5'h06, 8'd150);
		write_reg(5'h07, {len_idx, 3'b000});
		step(2000);
		read_status(8'h03, 8'h07);

		test_id = 4'd4;
		out_mode = 2'd0;
		write_reg(`REG_STATUS, 8'h00);
		step(3);
		v0 = 4'd0;
		v1 = 4'd0;
		out_mode = 2'd1;
		read_status(8'h00, 8'h07);
		step(20);

		test_id = 4'd5;
		write_reg(`REG_FRAME, 8'h00);
		wait_irq(1'b0, 40000, "irq did not go low in 4-step mode");
		read_status(8'h40, 8'h40);
		wait_irq(1'b1, 4, "irq did not return high after the status read");
		read_status(8'h00, 8'h40);
		write_reg(`REG_FRAME, 8'h80);
		irq_high = 1'b1;
		step(70000);
		irq_high = 1'b0;

		test_id = 4'd6;
		out_mode = 2'd2;
		len_idx = 5'($urandom % 32);
		write_reg(`REG_STATUS, 8'h04);
		write_reg(5'h08, 8'hFF); // control flag set, linear load 127
		write_reg(5'h0A, 8'd50);
		write_reg(5'h0B, {len_idx, 3'b000});
		wait_out_active(20000); // linear counter loads on the next quarter strobe
		step(3000);
		read_status(8'h04, 8'h07);

		test_id = 4'd15;
		wait_summary(10);
		if (errors == 0 && summary_done === 1'b1)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
apu_pkg.sv
apu_length.sv
apu_reg_decode.sv
apu_frame_seq.sv
apu_pulse.sv
apu_triangle.sv
apu_mixer.sv
apu_top.sv
apu_checker.sv
tb_apu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the APU testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/10ps \
	--top-module tb_apu \
	--Mdir obj_dir \
	-o sim_apu \
	-f build.f

./obj_dir/sim_apu 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation reported errors, see sim.log"
	exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
	echo "simulation ended without a result line, see sim.log"
	exit 1
fi

echo "simulation clean"
